/* logic/i2c_config.svh */
`ifndef I2C_CONFIG_SVH
`define I2C_CONFIG_SVH

// clk cycles per scl period, 25 MHz / 20 kHz
// short simulation runs override the top level parameter instead
`define I2C_SCL_DIV     1250

// host register offsets
`define I2C_REG_DEV     0
`define I2C_REG_REG     1
`define I2C_REG_WDATA   2
`define I2C_REG_CTRL    3
`define I2C_REG_RDATA   4
`define I2C_REG_STATUS  5

`define I2C_OFS_W       3       // register offset bits
`define I2C_DEV_W       7       // 7-bit device address
`define I2C_DATA_W      8

`endif

/* logic/i2c_pkg.sv */
`include "i2c_config.svh"

package i2c_pkg;

    // register index as seen on the host port
    typedef enum logic [`I2C_OFS_W-1:0] {
        idx_dev    = `I2C_REG_DEV,
        idx_reg    = `I2C_REG_REG,
        idx_wdata  = `I2C_REG_WDATA,
        idx_ctrl   = `I2C_REG_CTRL,
        idx_rdata  = `I2C_REG_RDATA,
        idx_status = `I2C_REG_STATUS
    } reg_idx_e;

    typedef struct packed {
        logic                   write;
        logic [`I2C_OFS_W-1:0]  offset;
        logic [`I2C_DATA_W-1:0] wdata;
    } host_req_t;

    // one bus transaction, latched by the engine at start
    typedef struct packed {
        logic [`I2C_DEV_W-1:0]  dev_addr;
        logic [`I2C_DATA_W-1:0] reg_addr;
        logic [`I2C_DATA_W-1:0] wdata;
        logic                   is_read;
    } i2c_cmd_t;

    typedef struct packed {
        logic [`I2C_DATA_W-1:0] rdata;
        logic                   nack;   // any ack slot seen high
    } i2c_result_t;

endpackage

/* logic/i2c_csr.sv */
`timescale 1ns/10ps
`include "i2c_config.svh"

module i2c_csr
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   req,
    input  i2c_pkg::host_req_t     host_req,
    output logic                   ack,
    output logic [`I2C_DATA_W-1:0] rdata,
    output i2c_pkg::i2c_cmd_t      cmd,
    output logic                   start,
    input  logic                   done,
    input  i2c_pkg::i2c_result_t   result
);
    import i2c_pkg::*;

    logic [`I2C_DEV_W-1:0]  dev_addr;
    logic [`I2C_DATA_W-1:0] reg_addr;
    logic [`I2C_DATA_W-1:0] wr_data;
    logic [`I2C_DATA_W-1:0] rx_data;   // last byte received
    logic                   busy;
    logic                   nack;
    logic                   accept;
    logic                   launch;
    logic [`I2C_DATA_W-1:0] rd_val;
    reg_idx_e               idx;

    assign idx    = reg_idx_e'(host_req.offset);
    assign accept = req && !ack;   // first cycle of a new access

    // valid ctrl write: not busy and at least one request bit
    assign launch = accept && host_req.write && (idx == idx_ctrl) && !busy
                    && (host_req.wdata[1:0] != 2'b00);

    //**************************************************************************
    // four-phase responder
    //**************************************************************************
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            ack <= 1'b0;
        else
            ack <= req;   // rises one clock after req, falls one after it drops
    end

    always_comb
    begin
        rd_val = '0;
        case (idx)
            idx_dev:    rd_val[`I2C_DEV_W-1:0] = dev_addr;
            idx_reg:    rd_val = reg_addr;
            idx_wdata:  rd_val = wr_data;
            idx_rdata:  rd_val = rx_data;
            idx_status: rd_val[1:0] = {nack, busy};
            default:    rd_val = '0;   // ctrl reads back zero
        endcase
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            dev_addr <= '0;
            reg_addr <= '0;
            wr_data  <= '0;
            rdata    <= '0;
        end
        else if (accept)
        begin
            if (!host_req.write)
                rdata <= rd_val;
            else
            begin
                case (idx)
                    idx_dev:   dev_addr <= host_req.wdata[`I2C_DEV_W-1:0];
                    idx_reg:   reg_addr <= host_req.wdata;
                    idx_wdata: wr_data  <= host_req.wdata;
                    default:   ;
                endcase
            end
        end
    end

    //**************************************************************************
    // command launch and completion
    //**************************************************************************
    always_ff @(posedge clk)
    begin
        if (launch)
            cmd <= '{dev_addr: dev_addr, reg_addr: reg_addr, wdata: wr_data,
                     is_read: host_req.wdata[1]};   // read wins if both set
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            start   <= 1'b0;
            busy    <= 1'b0;
            nack    <= 1'b0;
            rx_data <= '0;
        end
        else
        begin
            start <= launch;
            if (done)
            begin
                busy <= 1'b0;
                nack <= result.nack;
                if (cmd.is_read)
                    rx_data <= result.rdata;
            end
            else if (launch)
                busy <= 1'b1;
        end
    end

    a_ack_after_req: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(ack) |-> $past(req));

    // a start pulse opens a new busy window, never lands inside one
    a_start_not_busy: assert property (@(posedge clk) disable iff (!reset_n)
        start |-> busy && !$past(busy));

endmodule

/* logic/i2c_byte_engine.sv */
`timescale 1ns/10ps
`include "i2c_config.svh"

module i2c_byte_engine
#(
    parameter int scl_div = `I2C_SCL_DIV
)
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  i2c_pkg::i2c_cmd_t    cmd,
    input  logic                 start,
    output logic                 done,
    output i2c_pkg::i2c_result_t result,
    output logic                 scl,
    output logic                 sda_oe,
    output logic                 sda_out,
    input  logic                 sda_in
);
    import i2c_pkg::*;

    localparam int cnt_w = $clog2(scl_div);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(scl_div - 1);
    localparam logic [cnt_w-1:0] cnt_half = cnt_w'(scl_div / 2);
    localparam logic [cnt_w-1:0] cnt_qtr  = cnt_w'(scl_div / 4);

    typedef enum logic [3:0] {
        st_idle, st_start0, st_wr_dev, st_ack_dev, st_wr_reg, st_ack_reg,
        st_wr_data, st_ack_data, st_start1, st_rd_dev, st_ack_rd_dev,
        st_rd_data, st_no_ack, st_stop
    } state_e;

    state_e                 state;
    logic [cnt_w-1:0]       cnt;
    logic                   scl_hs;
    logic                   scl_hc;
    logic                   scl_ls;
    logic                   scl_lc;
    logic                   go_pend;   // start taken, waiting for high-centre
    logic                   engine_idle;
    logic [2:0]             bcnt;
    logic [`I2C_DATA_W-1:0] shreg;     // outgoing byte, msb first
    logic [`I2C_DATA_W-1:0] rx_byte;
    logic                   nack_acc;
    i2c_cmd_t               cmd_q;

    function automatic state_e ack_after(input state_e s);
        case (s)
            st_wr_dev:  return st_ack_dev;
            st_wr_reg:  return st_ack_reg;
            st_wr_data: return st_ack_data;
            default:    return st_ack_rd_dev;
        endcase
    endfunction

    //**************************************************************************
    // scl divider and phase strobes
    //**************************************************************************
    assign scl_hs = (cnt == '0);
    assign scl_hc = (cnt == cnt_qtr);
    assign scl_ls = (cnt == cnt_half);
    assign scl_lc = (cnt == cnt_half + cnt_qtr);

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            cnt <= '0;
            scl <= 1'b1;
        end
        else
        begin
            cnt <= (cnt == cnt_last) ? '0 : cnt + cnt_w'(1);
            if (scl_hs)
                scl <= 1'b1;
            else if (scl_ls)
                scl <= 1'b0;
        end
    end

    assign engine_idle = (state == st_idle) && !go_pend;
    assign result      = '{rdata: rx_byte, nack: nack_acc};

    always_ff @(posedge clk)
    begin
        if (start && engine_idle)
            cmd_q <= cmd;
        if ((state == st_rd_data) && scl_hc)
            rx_byte <= {rx_byte[`I2C_DATA_W-2:0], sda_in};
    end

    //**************************************************************************
    // transaction fsm, sda changes at low-centre
    //**************************************************************************
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            state    <= st_idle;
            go_pend  <= 1'b0;
            bcnt     <= '0;
            shreg    <= '0;
            sda_oe   <= 1'b1;   // bus released high
            sda_out  <= 1'b1;
            done     <= 1'b0;
            nack_acc <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start && engine_idle)
            begin
                go_pend  <= 1'b1;
                nack_acc <= 1'b0;
            end
            case (state)
                st_idle:
                begin
                    sda_oe <= 1'b1;
                    if (go_pend && scl_hc)
                    begin
                        go_pend <= 1'b0;
                        state   <= st_start0;
                    end
                end
                st_start0:
                begin
                    if (scl_lc)
                    begin
                        state   <= st_wr_dev;
                        bcnt    <= '0;
                        shreg   <= {cmd_q.dev_addr, 1'b0};
                        sda_out <= cmd_q.dev_addr[`I2C_DEV_W-1];
                    end
                    else
                        sda_out <= 1'b0;   // start, sda falls with scl high
                end
                st_wr_dev, st_wr_reg, st_wr_data, st_rd_dev:
                begin
                    if (scl_lc)
                    begin
                        if (bcnt == 3'd7)
                        begin
                            state  <= ack_after(state);
                            sda_oe <= 1'b0;   // target owns the ack slot
                        end
                        else
                        begin
                            bcnt    <= bcnt + 3'd1;
                            shreg   <= {shreg[`I2C_DATA_W-2:0], 1'b0};
                            sda_out <= shreg[`I2C_DATA_W-2];
                        end
                    end
                end
                st_ack_dev, st_ack_reg, st_ack_data, st_ack_rd_dev:
                begin
                    if (scl_hc && sda_in)
                        nack_acc <= 1'b1;
                    if (scl_lc)
                    begin
                        sda_oe <= 1'b1;
                        bcnt   <= '0;
                        case (state)
                            st_ack_dev:
                            begin
                                state   <= st_wr_reg;
                                shreg   <= cmd_q.reg_addr;
                                sda_out <= cmd_q.reg_addr[`I2C_DATA_W-1];
                            end
                            st_ack_reg:
                            begin
                                if (cmd_q.is_read)
                                begin
                                    state   <= st_start1;
                                    sda_out <= 1'b1;   // high before repeated start
                                end
                                else
                                begin
                                    state   <= st_wr_data;
                                    shreg   <= cmd_q.wdata;
                                    sda_out <= cmd_q.wdata[`I2C_DATA_W-1];
                                end
                            end
                            st_ack_data:
                            begin
                                state   <= st_stop;
                                sda_out <= 1'b0;
                            end
                            default:
                            begin
                                state  <= st_rd_data;
                                sda_oe <= 1'b0;
                            end
                        endcase
                    end
                end
                st_start1:
                begin
                    if (scl_hc)
                        sda_out <= 1'b0;   // repeated start
                    else if (scl_lc)
                    begin
                        state   <= st_rd_dev;
                        bcnt    <= '0;
                        shreg   <= {cmd_q.dev_addr, 1'b1};
                        sda_out <= cmd_q.dev_addr[`I2C_DEV_W-1];
                    end
                end
                st_rd_data:
                begin
                    if (scl_lc)
                    begin
                        if (bcnt == 3'd7)
                        begin
                            state   <= st_no_ack;
                            sda_oe  <= 1'b1;
                            sda_out <= 1'b1;   // master nack ends the read
                        end
                        else
                            bcnt <= bcnt + 3'd1;
                    end
                end
                st_no_ack:
                begin
                    if (scl_lc)
                    begin
                        state   <= st_stop;
                        sda_out <= 1'b0;
                    end
                end
                st_stop:
                begin
                    if (scl_hc)
                    begin
                        sda_out <= 1'b1;   // stop, sda rises with scl high
                        done    <= 1'b1;
                        state   <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // data may only move under scl high to form start, repeated start or stop
    a_sda_moves_low: assert property (@(posedge clk) disable iff (!reset_n)
        $changed(sda_out) |-> !$past(scl)
                              || ($past(state) inside {st_start0, st_start1, st_stop}));

    a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        done |=> !done);

endmodule

/* logic/i2c_master_top.sv */
`timescale 1ns/10ps
`include "i2c_config.svh"

module i2c_master_top
#(
    parameter int scl_div = `I2C_SCL_DIV
)
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   req,
    input  i2c_pkg::host_req_t     host_req,
    output logic                   ack,
    output logic [`I2C_DATA_W-1:0] rdata,
    output logic                   scl,
    output logic                   sda_oe,
    output logic                   sda_out,
    input  logic                   sda_in
);
    import i2c_pkg::*;

    i2c_cmd_t    cmd;
    i2c_result_t result;
    logic        start;
    logic        done;

    // host registers and command launch
    i2c_csr i_csr
    (
        .clk      (clk),
        .reset_n  (reset_n),
        .req      (req),
        .host_req (host_req),
        .ack      (ack),
        .rdata    (rdata),
        .cmd      (cmd),
        .start    (start),
        .done     (done),
        .result   (result)
    );

    i2c_byte_engine #(.scl_div(scl_div)) i_engine
    (
        .clk      (clk),
        .reset_n  (reset_n),
        .cmd      (cmd),
        .start    (start),
        .done     (done),
        .result   (result),
        .scl      (scl),
        .sda_oe   (sda_oe),     // open-drain control, pad lives outside
        .sda_out  (sda_out),
        .sda_in   (sda_in)
    );

endmodule

/* dv/i2c_slave_model.sv */
`timescale 1ns/10ps

module i2c_slave_model
#(
    parameter logic [6:0] dev_addr = 7'h50
)
(
    input  logic scl,
    input  logic sda,         // resolved bus line
    output logic hold_low     // pulls the wired-AND line down
);
    typedef enum {ph_idle, ph_addr, ph_reg, ph_wdata, ph_rdata} phase_e;

    logic [7:0] mem [0:255];
    int         start_count = 0;        // starts from a free bus only
    phase_e     phase       = ph_idle;
    logic       bus_active  = 1'b0;
    logic       in_ack      = 1'b0;
    logic       is_read     = 1'b0;
    logic       master_nack = 1'b0;
    int         bit_cnt     = 0;
    logic [7:0] shift       = '0;
    logic [7:0] tx          = '0;
    logic [7:0] ptr         = '0;       // register pointer
    logic       scl_q       = 1'b1;
    logic       sda_q       = 1'b1;

    initial
        hold_low = 1'b0;

    task automatic preload(input logic [7:0] addr, input logic [7:0] value);
        mem[addr] = value;
    endtask

    task automatic sample_bit();
        if (bit_cnt < 8)
        begin
            if (phase != ph_rdata)
                shift = {shift[6:0], sda};
            bit_cnt++;
        end
        else if (phase == ph_rdata)
            master_nack = sda;    // ninth clock of a read byte
    endtask

    // bus changes only while scl is low
    task automatic drive_bit();
        if (bit_cnt == 8 && !in_ack)
        begin
            in_ack   = 1'b1;
            hold_low = 1'b1;
            case (phase)
                ph_addr:
                begin
                    if (shift[7:1] == dev_addr)
                        is_read = shift[0];
                    else
                    begin
                        hold_low = 1'b0;   // not addressed, sit out until next start
                        phase    = ph_idle;
                    end
                end
                ph_reg:   ptr = shift;
                ph_wdata:
                begin
                    mem[ptr] = shift;
                    ptr++;
                end
                default:  hold_low = 1'b0;   // master owns the ack slot of a read
            endcase
        end
        else if (in_ack)
        begin
            in_ack   = 1'b0;
            bit_cnt  = 0;
            hold_low = 1'b0;
            case (phase)
                ph_addr:  phase = is_read ? ph_rdata : ph_reg;
                ph_reg:   phase = ph_wdata;
                ph_rdata:
                begin
                    if (master_nack)
                        phase = ph_idle;
                    else
                        ptr++;
                end
                default:  ;
            endcase
            if (phase == ph_rdata)
            begin
                tx       = mem[ptr];
                hold_low = !tx[7];
            end
        end
        else if (phase == ph_rdata && bit_cnt < 8)
            hold_low = !tx[7 - bit_cnt];
    endtask

    //**************************************************************************
    // bus watcher
    //**************************************************************************
    always @(scl or sda)
    begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda === 1'b0 && sda_q === 1'b1)
        begin
            if (!bus_active)
                start_count++;    // repeated start not counted
            bus_active = 1'b1;
            phase      = ph_addr;
            bit_cnt    = 0;
            in_ack     = 1'b0;
            hold_low   = 1'b0;
        end
        else if (scl === 1'b1 && scl_q === 1'b1 && sda === 1'b1 && sda_q === 1'b0)
        begin
            bus_active = 1'b0;    // stop
            phase      = ph_idle;
            hold_low   = 1'b0;
        end
        else if (scl === 1'b1 && scl_q === 1'b0 && phase != ph_idle)
            sample_bit();
        else if (scl === 1'b0 && scl_q === 1'b1 && phase != ph_idle)
            drive_bit();
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* dv/tb_i2c_master.sv */
`timescale 1ns/10ps

module tb_i2c_master;
    import i2c_pkg::*;

    localparam int scl_div     = 64;
    localparam int clk_period  = 100;
    localparam int watchdog_ns = 12 * 45 * scl_div * clk_period;

    logic        clk;
    logic        reset_n;
    logic        req;
    host_req_t   host_req;
    logic        ack;
    logic [7:0]  rdata;
    logic        scl;
    logic        sda_oe;
    logic        sda_out;
    logic        sda_line;
    logic        slave_hold_low;

    logic [7:0]  ref_mem [0:255];   // expected target memory
    integer      seed;
    int          expected_starts;
    logic        check_en;
    logic        count_en;
    string       check_name;
    logic [7:0]  check_exp;
    logic [7:0]  check_act;

    i2c_master_top #(.scl_div(scl_div)) i_dut
    (
        .clk      (clk),
        .reset_n  (reset_n),
        .req      (req),
        .host_req (host_req),
        .ack      (ack),
        .rdata    (rdata),
        .scl      (scl),
        .sda_oe   (sda_oe),
        .sda_out  (sda_out),
        .sda_in   (sda_line)
    );

    i2c_slave_model #(.dev_addr(7'h50)) i_slave
    (
        .scl      (scl),
        .sda      (sda_line),
        .hold_low (slave_hold_low)
    );

    assign sda_line = (sda_oe ? sda_out : 1'b1) & !slave_hold_low;   // wired-AND

    always #(clk_period / 2) clk = ~clk;

    //**************************************************************************
    // failure reporting
    //**************************************************************************
    task automatic stop_on_failure();
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_failed(input string name, input logic [7:0] exp,
                                input logic [7:0] act);
        $display("FAILED %s: expected 0x%02h, actual 0x%02h", name, exp, act);
        stop_on_failure();
    endtask

    task automatic plain_failure(input string why);
        $display("ERROR: %s", why);
        stop_on_failure();
    endtask

    a_value: assert property (@(posedge clk) check_en |-> (check_act == check_exp))
        else value_failed(check_name, check_exp, check_act);

    a_starts: assert property (@(posedge clk)
        count_en |-> (i_slave.start_count == expected_starts))
        else value_failed("transactions at slave", 8'(expected_starts),
                          8'(i_slave.start_count));

    a_ack_rise: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(ack) |-> $past(req))
        else plain_failure("ack rose while req was low");

    a_ack_fall: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(ack) |-> !$past(req))
        else plain_failure("ack fell while req was still high");

    //**************************************************************************
    // host port and check strobes
    //**************************************************************************
    task automatic expect_value(input string name, input logic [7:0] exp,
                                input logic [7:0] act);
        check_name = name;
        check_exp  = exp;
        check_act  = act;
        check_en   = 1'b1;
        @(posedge clk);
        #1;
        check_en   = 1'b0;
    endtask

    task automatic expect_transactions();
        count_en = 1'b1;
        @(posedge clk);
        #1;
        count_en = 1'b0;
    endtask

    // full four-phase access, entered 1 ns after a rising edge
    task automatic host_access(input logic is_write, input reg_idx_e idx,
                               input logic [7:0] wdata, output logic [7:0] data);
        host_req = '{write: is_write, offset: idx, wdata: wdata};
        req      = 1'b1;
        do
        begin
            @(posedge clk);
            #1;
        end
        while (ack !== 1'b1);
        data = rdata;
        req  = 1'b0;
        do
        begin
            @(posedge clk);
            #1;
        end
        while (ack !== 1'b0);
    endtask

    task automatic reg_write(input reg_idx_e idx, input logic [7:0] value);
        logic [7:0] ignored;
        host_access(1'b1, idx, value, ignored);
    endtask

    task automatic reg_read(input reg_idx_e idx, output logic [7:0] value);
        host_access(1'b0, idx, 8'h00, value);
    endtask

    task automatic wait_not_busy();
        logic [7:0] status;
        status = 8'h01;
        while (status[0])
            reg_read(idx_status, status);
    endtask

    task automatic run_command(input logic [6:0] dev, input logic [7:0] addr,
                               input logic [7:0] data, input logic is_read);
        reg_write(idx_dev, {1'b0, dev});
        reg_write(idx_reg, addr);
        reg_write(idx_wdata, data);
        reg_write(idx_ctrl, is_read ? 8'h02 : 8'h01);
        expected_starts++;
        wait_not_busy();
    endtask

    //**************************************************************************
    // stimulus
    //**************************************************************************
    initial
    begin
        logic [7:0] value;
        logic [7:0] addr;
        logic [7:0] data;
        int         i;

        clk             = 1'b0;
        reset_n         = 1'b0;
        req             = 1'b0;
        host_req        = '0;
        check_en        = 1'b0;
        count_en        = 1'b0;
        check_name      = "";
        check_exp       = '0;
        check_act       = '0;
        expected_starts = 0;
        seed            = 49517;

        for (i = 0; i < 256; i++)
        begin
            data       = 8'($random(seed));
            ref_mem[i] = data;
            i_slave.preload(8'(i), data);
        end

        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // reset state
        expect_value("ack after reset", 8'h00, {7'b0, ack});
        expect_value("bus after reset", 8'h07, {5'b0, scl, sda_oe, sda_out});
        reg_read(idx_status, value);
        expect_value("status after reset", 8'h00, value);

        // register readback
        reg_write(idx_dev, 8'h2c);
        reg_write(idx_reg, 8'ha5);
        reg_write(idx_wdata, 8'h3c);
        reg_read(idx_dev, value);
        expect_value("dev readback", 8'h2c, value);
        reg_read(idx_reg, value);
        expect_value("reg readback", 8'ha5, value);
        reg_read(idx_wdata, value);
        expect_value("wdata readback", 8'h3c, value);
        reg_read(idx_ctrl, value);
        expect_value("ctrl readback", 8'h00, value);

        // write, then read the same register back
        for (i = 0; i < 2; i++)
        begin
            addr = 8'($random(seed));
            data = 8'($random(seed));
            run_command(7'h50, addr, data, 1'b0);
            ref_mem[addr] = data;
            reg_read(idx_status, value);
            expect_value("write status", 8'h00, value);
            run_command(7'h50, addr, 8'h00, 1'b1);
            reg_read(idx_rdata, value);
            expect_value("write readback", ref_mem[addr], value);
            reg_read(idx_status, value);
            expect_value("readback status", 8'h00, value);
        end
        expect_transactions();

        // reads of preloaded bytes
        for (i = 0; i < 3; i++)
        begin
            addr = 8'(i * 127);
            run_command(7'h50, addr, 8'h00, 1'b1);
            reg_read(idx_rdata, value);
            expect_value("preload read", ref_mem[addr], value);
            reg_read(idx_status, value);
            expect_value("preload status", 8'h00, value);
        end

        // nobody answers at 0x23
        run_command(7'h23, 8'h10, 8'hc3, 1'b0);
        reg_read(idx_status, value);
        expect_value("missing device write", 8'h02, value);
        expect_value("missing device memory", ref_mem[8'h10], i_slave.mem[8'h10]);
        run_command(7'h23, 8'h10, 8'h00, 1'b1);
        reg_read(idx_status, value);
        expect_value("missing device read", 8'h02, value);

        // second ctrl write lands while busy
        reg_write(idx_dev, 8'h50);
        reg_write(idx_reg, 8'h42);
        reg_write(idx_wdata, 8'h99);
        reg_write(idx_ctrl, 8'h01);
        expected_starts++;
        reg_read(idx_status, value);
        expect_value("busy after ctrl", 8'h01, {7'b0, value[0]});
        reg_write(idx_ctrl, 8'h02);
        wait_not_busy();
        ref_mem[8'h42] = 8'h99;
        expect_transactions();
        reg_read(idx_status, value);
        expect_value("status after busy rule", 8'h00, value);
        expect_value("busy rule write", ref_mem[8'h42], i_slave.mem[8'h42]);

        $display("All tests passed");
        $finish;
    end

    // 12 transactions of up to 45 scl periods
    initial
    begin
        #(watchdog_ns);
        plain_failure("timeout, the transactions did not finish in time");
    end

endmodule

/* compile.f */
+incdir+logic
logic/i2c_pkg.sv
logic/i2c_csr.sv
logic/i2c_byte_engine.sv
logic/i2c_master_top.sv
dv/i2c_slave_model.sv
dv/tb_i2c_master.sv

/* Makefile */
TOP = tb_i2c_master

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module i2c_master_top

sim:
	verilator --binary --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Some tests failed" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "All tests passed" sim.log; then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
